// ==== src/pw_cfg_pkg.sv ====
package pw_cfg_pkg;

   //////////////////////////////////////////////////
   // sniffer configuration widths
   //////////////////////////////////////////////////

   localparam int DEF_PATTERN_BYTES = 64;  // leading bytes compared per packet
   localparam int DELAY_W           = 20;  // trigger delay, fe_clk cycles
   localparam int WIDTH_W           = 17;  // trigger pulse width, fe_clk cycles
   localparam int NUM_TRIG_W        = 4;   // trigger budget per session

   // timer must hold whichever interval is wider
   localparam int TMR_W = (DELAY_W > WIDTH_W) ? DELAY_W : WIDTH_W;

   //////////////////////////////////////////////////
   // data types
   //////////////////////////////////////////////////

   typedef logic [7:0]            byte_t;      // one UTMI rx byte
   typedef logic [DELAY_W-1:0]    delay_t;
   typedef logic [WIDTH_W-1:0]    width_t;
   typedef logic [NUM_TRIG_W-1:0] trig_cnt_t;  // budget and pulse count
   typedef logic [TMR_W-1:0]      tmr_val_t;   // timer load value

endpackage

// ==== src/pw_trig_pkg.sv ====
package pw_trig_pkg;

   //////////////////////////////////////////////////
   // trigger sequencer states
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,  // disarmed, matches ignored
      ST_ARMED = 2'd1,  // waiting for a pattern match
      ST_DELAY = 2'd2,  // counting down the trigger delay
      ST_PULSE = 2'd3   // cw trigger output high
   } trig_state_e;

   //////////////////////////////////////////////////
   // interval timer commands
   //////////////////////////////////////////////////

   typedef enum logic {
      TMR_NONE = 1'b0,  // keep counting
      TMR_LOAD = 1'b1   // restart with load_val
   } timer_cmd_e;

endpackage

// ==== src/timer_if.sv ====
`timescale 1ns/1ps

interface timer_if
   import pw_cfg_pkg::*, pw_trig_pkg::*;
();

   timer_cmd_e cmd;       // one cycle of TMR_LOAD starts an interval
   tmr_val_t   load_val;  // interval length in cycles
   logic       done;      // one cycle, after the count hits zero
   logic       busy;      // count still nonzero

   modport sequencer (
      output cmd,
      output load_val,
      input  done,
      input  busy
   );

   modport timer (
      input  cmd,
      input  load_val,
      output done,
      output busy
   );

endinterface

// ==== src/usb_pattern_matcher.sv ====
`timescale 1ns/1ps

module usb_pattern_matcher
   import pw_cfg_pkg::*;
#(
   parameter int PATTERN_BYTES = DEF_PATTERN_BYTES
) (
   input  logic                               fe_clk_i,
   input  logic                               rst_n_i,
   input  byte_t                              fe_data_i,
   input  logic                               fe_rxvalid_i,
   input  logic                               fe_rxactive_i,
   input  logic [PATTERN_BYTES*8-1:0]         pattern_i,
   input  logic [PATTERN_BYTES*8-1:0]         mask_i,
   input  logic [$clog2(PATTERN_BYTES+1)-1:0] pattern_bytes_i,
   output logic                               match_o
);

   localparam int IDX_W = $clog2(PATTERN_BYTES+1);

   logic             rxactive_q;   // for start of packet detect
   logic             sop;
   logic [IDX_W-1:0] idx_q;        // next byte to compare
   logic [IDX_W-1:0] idx_eff;
   logic             equal_q;      // all compared bytes equal so far
   logic             equal_eff;
   logic             compare_en;
   logic             last_byte;
   byte_t            pat_byte;
   byte_t            mask_byte;
   logic             byte_ok;

   //////////////////////////////////////////////////
   // byte compare
   //////////////////////////////////////////////////

   // a new packet may deliver its first byte in the same cycle rxactive rises
   assign sop       = fe_rxactive_i & ~rxactive_q;
   assign idx_eff   = sop ? '0 : idx_q;
   assign equal_eff = sop | equal_q;

   // bytes past pattern_bytes_i are ignored
   assign compare_en = fe_rxvalid_i & fe_rxactive_i & (idx_eff < pattern_bytes_i);
   assign last_byte  = (idx_eff == pattern_bytes_i - 1'b1);

   assign pat_byte  = pattern_i[idx_eff*8 +: 8];
   assign mask_byte = mask_i[idx_eff*8 +: 8];
   assign byte_ok   = ((fe_data_i ^ pat_byte) & mask_byte) == 8'h00;  // mask 1 = compare

   //////////////////////////////////////////////////
   // packet tracking and match strobe
   //////////////////////////////////////////////////

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         rxactive_q <= 1'b0;
         idx_q      <= '0;
         equal_q    <= 1'b0;
         match_o    <= 1'b0;
      end
      else begin
         rxactive_q <= fe_rxactive_i;
         match_o    <= 1'b0;                       // single cycle strobe
         if (compare_en) begin
            idx_q   <= idx_eff + 1'b1;
            equal_q <= equal_eff & byte_ok;
            match_o <= last_byte & equal_eff & byte_ok;
         end
         else if (sop) begin
            idx_q   <= '0;                         // packet start, no valid byte yet
            equal_q <= 1'b1;
         end
      end
   end

   // pattern length must be legal for as long as a packet is on the bus
   a_pattern_bytes_legal: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i)
      fe_rxactive_i |-> (pattern_bytes_i != '0) && (pattern_bytes_i <= PATTERN_BYTES)
   ) else $error("pattern_bytes_i out of range during a packet");

endmodule

// ==== src/trigger_sequencer.sv ====
`timescale 1ns/1ps

module trigger_sequencer
   import pw_cfg_pkg::*, pw_trig_pkg::*;
(
   input  logic              fe_clk_i,
   input  logic              rst_n_i,
   input  logic              arm_i,
   input  logic              match_i,
   input  trig_cnt_t         num_triggers_i,
   input  delay_t            delay_i,
   input  width_t            width_i,
   timer_if.sequencer        tmr,
   output logic              cw_trig_o,
   output logic              armed_o,
   output trig_cnt_t         trig_count_o
);

   trig_state_e state_q;
   trig_state_e state_d;
   logic        arm_q;
   logic        arm_rise;      // arm request, also restarts a running session
   logic        budget_spent;
   trig_cnt_t   count_inc;
   trig_cnt_t   count_d;
   logic        cw_trig_d;

   assign arm_rise     = arm_i & ~arm_q;
   assign budget_spent = (trig_count_o >= num_triggers_i);
   assign count_inc    = trig_count_o + 1'b1;

   // pulse goes high one edge after entering ST_PULSE and drops on timer done
   assign cw_trig_d = (state_q == ST_PULSE) & ~tmr.done & ~arm_rise;

   //////////////////////////////////////////////////
   // next state and timer commands
   //////////////////////////////////////////////////

   always_comb begin
      state_d      = state_q;
      count_d      = trig_count_o;
      tmr.cmd      = TMR_NONE;
      tmr.load_val = tmr_val_t'(delay_i);
      if (arm_rise) begin
         state_d = ST_ARMED;
         count_d = '0;
      end
      else begin
         case (state_q)
            ST_IDLE: begin
               state_d = ST_IDLE;                           // wait for arm
            end
            ST_ARMED: begin
               if (budget_spent) begin
                  state_d = ST_IDLE;                        // zero budget
               end
               else if (match_i) begin
                  tmr.cmd = TMR_LOAD;                       // start delay
                  state_d = ST_DELAY;
               end
            end
            ST_DELAY: begin
               if (tmr.done) begin
                  tmr.cmd      = TMR_LOAD;
                  tmr.load_val = tmr_val_t'(width_i);       // start pulse width
                  state_d      = ST_PULSE;
               end
            end
            ST_PULSE: begin
               if (tmr.done) begin
                  count_d = count_inc;
                  state_d = (count_inc >= num_triggers_i) ? ST_IDLE : ST_ARMED;
               end
            end
            default: begin
               state_d = ST_IDLE;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         state_q      <= ST_IDLE;
         arm_q        <= 1'b0;
         trig_count_o <= '0;
         cw_trig_o    <= 1'b0;
         armed_o      <= 1'b0;
      end
      else begin
         state_q      <= state_d;
         arm_q        <= arm_i;
         trig_count_o <= count_d;
         cw_trig_o    <= cw_trig_d;
         armed_o      <= (state_d != ST_IDLE);    // tracks state_q
      end
   end

   a_trig_only_in_pulse: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i)
      cw_trig_o |-> (state_q == ST_PULSE)
   ) else $error("cw_trig_o high outside ST_PULSE");

   a_count_within_budget: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i)
      trig_count_o <= num_triggers_i
   ) else $error("trigger count above budget");

   // timer must be running whenever an interval is being waited on
   a_timer_running: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i)
      (state_q inside {ST_DELAY, ST_PULSE}) |-> (tmr.busy || tmr.done)
   ) else $error("sequencer waiting on an idle timer");

endmodule

// ==== src/trigger_timer.sv ====
`timescale 1ns/1ps

module trigger_timer
   import pw_cfg_pkg::*, pw_trig_pkg::*;
(
   input  logic    fe_clk_i,
   input  logic    rst_n_i,
   timer_if.timer  tmr
);

   tmr_val_t count_q;  // remaining busy cycles
   logic     busy_q;   // count still nonzero
   logic     done_q;   // one cycle after the count hits zero

   // load of N gives N busy cycles, then one done cycle
   assign tmr.busy = busy_q;
   assign tmr.done = done_q;

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
         busy_q  <= 1'b0;
         done_q  <= 1'b0;
      end
      else if (tmr.cmd == TMR_LOAD) begin
         count_q <= tmr.load_val;          // reload wins over a pending done
         busy_q  <= (tmr.load_val != '0);
         done_q  <= (tmr.load_val == '0);  // zero load, done right away
      end
      else if (busy_q) begin
         count_q <= count_q - 1'b1;
         busy_q  <= (count_q != tmr_val_t'(1));
         done_q  <= (count_q == tmr_val_t'(1));
      end
      else begin
         done_q  <= 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // done comes straight after a load of zero or after the last busy cycle
   a_done_after_load: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i)
      tmr.done |-> ($past(tmr.cmd) == TMR_LOAD) || $past(tmr.busy)
   ) else $error("timer done without a preceding load");

   a_done_busy_excl: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i)
      !(tmr.done && tmr.busy)
   ) else $error("timer done and busy together");

endmodule

// ==== src/pw_sniffer_top.sv ====
`timescale 1ns/1ps

module pw_sniffer_top
   import pw_cfg_pkg::*;
#(
   parameter int PATTERN_BYTES = DEF_PATTERN_BYTES
) (
   input  logic                               fe_clk_i,
   input  logic                               rst_n_i,

   // UTMI receive stream
   input  byte_t                              fe_data_i,
   input  logic                               fe_rxvalid_i,
   input  logic                               fe_rxactive_i,

   // configuration
   input  logic                               arm_i,
   input  logic [PATTERN_BYTES*8-1:0]         pattern_i,
   input  logic [PATTERN_BYTES*8-1:0]         mask_i,
   input  logic [$clog2(PATTERN_BYTES+1)-1:0] pattern_bytes_i,
   input  trig_cnt_t                          num_triggers_i,
   input  delay_t                             delay_i,
   input  width_t                             width_i,

   // trigger and status
   output logic                               cw_trig_o,
   output logic                               armed_o,
   output trig_cnt_t                          trig_count_o
);

   logic match;  // one cycle after the last compared byte

   timer_if tmr_if ();

   //////////////////////////////////////////////////
   // packet pattern match
   //////////////////////////////////////////////////

   usb_pattern_matcher #(
      .PATTERN_BYTES    (PATTERN_BYTES)
   ) u_usb_pattern_matcher (
      .fe_clk_i         (fe_clk_i),
      .rst_n_i          (rst_n_i),
      .fe_data_i        (fe_data_i),
      .fe_rxvalid_i     (fe_rxvalid_i),
      .fe_rxactive_i    (fe_rxactive_i),
      .pattern_i        (pattern_i),
      .mask_i           (mask_i),
      .pattern_bytes_i  (pattern_bytes_i),
      .match_o          (match)
   );

   //////////////////////////////////////////////////
   // trigger generation
   //////////////////////////////////////////////////

   trigger_sequencer u_trigger_sequencer (
      .fe_clk_i         (fe_clk_i),
      .rst_n_i          (rst_n_i),
      .arm_i            (arm_i),
      .match_i          (match),
      .num_triggers_i   (num_triggers_i),
      .delay_i          (delay_i),
      .width_i          (width_i),
      .tmr              (tmr_if.sequencer),
      .cw_trig_o        (cw_trig_o),
      .armed_o          (armed_o),
      .trig_count_o     (trig_count_o)
   );

   trigger_timer u_trigger_timer (
      .fe_clk_i         (fe_clk_i),
      .rst_n_i          (rst_n_i),
      .tmr              (tmr_if.timer)   // delay and width intervals
   );

endmodule

// ==== include/pw_tb_cases.svh ====
`ifndef PW_TB_CASES_SVH
`define PW_TB_CASES_SVH

//////////////////////////////////////////////////
// stimulus and expectation table
//////////////////////////////////////////////////

// lead bytes hold the compared bytes, byte 0 in bits 7:0
task automatic build_case_table();
   // name, arm, overlap, packets, pattern, mask, bytes, lead,
   // delay, width, triggers, expected pulses
   add_case("delay0",         1, 0, 1, 64'h0000_0000_a5c3_2d69, 64'h0000_0000_ffff_ffff, 4,
            64'h0000_0000_a5c3_2d69,   0, 3, 1, 1);
   add_case("delay25",        1, 0, 1, 64'h1122_3344_5566_7788, 64'hffff_ffff_ffff_ffff, 8,
            64'h1122_3344_5566_7788,  25, 7, 1, 1);
   add_case("masked_random",  1, 0, 1, 64'h0000_00c0_ffee_d00d, 64'h0000_00f0_0fff_f0ff, 5,
            64'h0000_00c0_ffee_d00d,   5, 2, 1, 1);   // random under zero mask bits
   add_case("one_bit_off",    1, 0, 1, 64'h0000_0000_5a5a_5a5a, 64'h0000_0000_ffff_ffff, 4,
            64'h0000_0000_5a5a_5e5a,   2, 4, 1, 0);   // byte 1 bit 2 differs
   add_case("budget_two",     1, 0, 3, 64'h0000_0000_00e1_2d3c, 64'h0000_0000_00ff_ffff, 3,
            64'h0000_0000_00e1_2d3c,   4, 5, 2, 2);   // third packet unanswered
   add_case("disarmed",       0, 0, 1, 64'h0000_0000_00e1_2d3c, 64'h0000_0000_00ff_ffff, 3,
            64'h0000_0000_00e1_2d3c,   3, 3, 2, 0);   // count still 2 from the last session
   add_case("match_in_delay", 1, 1, 2, 64'h0000_0000_0077_8899, 64'h0000_0000_00ff_ffff, 3,
            64'h0000_0000_0077_8899, 120, 6, 3, 1);   // second packet lands in ST_DELAY
endtask

`endif

// ==== tb/tb_pw_sniffer.sv ====
`timescale 1ns/1ps

module tb_pw_sniffer
   import pw_cfg_pkg::*;
();

   localparam int PB_W = $clog2(DEF_PATTERN_BYTES+1);

   typedef logic [PB_W-1:0] pbytes_t;

   logic                           fe_clk = 1'b0;
   logic                           rst_n;
   byte_t                          fe_data;
   logic                           fe_rxvalid;
   logic                           fe_rxactive;
   logic                           arm;
   logic [DEF_PATTERN_BYTES*8-1:0] pattern;
   logic [DEF_PATTERN_BYTES*8-1:0] mask;
   pbytes_t                        pattern_bytes;
   trig_cnt_t                      num_triggers;
   delay_t                         delay;
   width_t                         width;
   logic                           cw_trig;
   logic                           armed;
   trig_cnt_t                      trig_count;

   // case table columns
   string       name_c[$];
   int          arm_c[$];
   int          overlap_c[$];
   int          npkt_c[$];
   logic [63:0] pat_c[$];
   logic [63:0] mask_c[$];
   int          pbytes_c[$];
   logic [63:0] lead_c[$];
   int          delay_c[$];
   int          width_c[$];
   int          ntrig_c[$];
   int          exp_c[$];

   int          cyc = 0;     // rising edges so far
   logic        trig_q = 1'b0;
   int          hi_cnt = 0;
   int          rise_q[$];   // edge of each cw_trig rise
   int          width_q[$];  // high time of each pulse
   int          e_q[$];      // edge of the last compared byte, per packet
   logic [31:0] rng = 32'h759c5d7f;
   int          errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   logic        timed_out = 1'b0;

   always #4 fe_clk = ~fe_clk;

   pw_sniffer_top #(
      .PATTERN_BYTES   (DEF_PATTERN_BYTES)
   ) pw_sniffer_top_i (
      .fe_clk_i        (fe_clk),
      .rst_n_i         (rst_n),
      .fe_data_i       (fe_data),
      .fe_rxvalid_i    (fe_rxvalid),
      .fe_rxactive_i   (fe_rxactive),
      .arm_i           (arm),
      .pattern_i       (pattern),
      .mask_i          (mask),
      .pattern_bytes_i (pattern_bytes),
      .num_triggers_i  (num_triggers),
      .delay_i         (delay),
      .width_i         (width),
      .cw_trig_o       (cw_trig),
      .armed_o         (armed),
      .trig_count_o    (trig_count)
   );

   //////////////////////////////////////////////////
   // pulse monitor
   //////////////////////////////////////////////////

   always @(posedge fe_clk) begin
      cyc    <= cyc + 1;
      trig_q <= cw_trig;
      if (cw_trig && !trig_q) begin
         rise_q.push_back(cyc - 1);          // rise happened at the previous edge
         hi_cnt = 1;
      end
      else if (cw_trig) begin
         hi_cnt = hi_cnt + 1;
      end
      else if (trig_q) begin
         width_q.push_back(hi_cnt);
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic add_case(input string name, input int arm_en, input int overlap,
                           input int npkt, input logic [63:0] pat, input logic [63:0] msk,
                           input int pbytes, input logic [63:0] lead, input int dly,
                           input int wid, input int ntrig, input int exp_pulses);
      name_c.push_back(name);
      arm_c.push_back(arm_en);
      overlap_c.push_back(overlap);
      npkt_c.push_back(npkt);
      pat_c.push_back(pat);
      mask_c.push_back(msk);
      pbytes_c.push_back(pbytes);
      lead_c.push_back(lead);
      delay_c.push_back(dly);
      width_c.push_back(wid);
      ntrig_c.push_back(ntrig);
      exp_c.push_back(exp_pulses);
   endtask

   `include "pw_tb_cases.svh"

   task automatic tick();
      @(posedge fe_clk);
   endtask

   task automatic report_mismatch(input string name, input string what,
                                  input int expected, input int actual);
      $display("** Error %s: %s expected %0d actual %0d", name, what, expected, actual);
      errors++;
   endtask

   task automatic arm_session();
      tick();
      arm <= 1'b1;
      tick();
      arm <= 1'b0;
      tick();
   endtask

   //////////////////////////////////////////////////
   // UTMI packet driver
   //////////////////////////////////////////////////

   task automatic send_packet(input int idx);
      byte_t b;
      byte_t m;
      int    trail;
      int    gap;
      int    k;
      rng   = xorshift32(rng);
      trail = 1 + int'(rng[1:0]);             // 1 to 4 bytes past the pattern
      gap   = 2 + int'(rng[10:8]);            // 2 to 9 idle cycles
      tick();
      fe_rxactive <= 1'b1;
      fe_rxvalid  <= 1'b0;
      for (k = 0; k < pbytes_c[idx] + trail; k++) begin
         rng = xorshift32(rng);
         if (k < pbytes_c[idx]) begin
            m = mask_c[idx][k*8 +: 8];
            b = (lead_c[idx][k*8 +: 8] & m) | (rng[7:0] & ~m);
         end
         else begin
            b = rng[7:0];
         end
         tick();
         if (k == pbytes_c[idx] - 1) begin
            e_q.push_back(cyc + 1);           // sampled at the coming edge
         end
         fe_data    <= b;
         fe_rxvalid <= 1'b1;
      end
      tick();
      fe_rxvalid  <= 1'b0;
      fe_rxactive <= 1'b0;
      for (k = 0; k < gap; k++) begin
         tick();
      end
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      int   i;
      int   p;
      int   w;
      int   limit;
      int   errs_before;
      logic seen;
      logic exp_armed;
      rst_n         <= 1'b0;
      fe_data       <= '0;
      fe_rxvalid    <= 1'b0;
      fe_rxactive   <= 1'b0;
      arm           <= 1'b0;
      pattern       <= '0;
      mask          <= '0;
      pattern_bytes <= pbytes_t'(1);
      num_triggers  <= '0;
      delay         <= '0;
      width         <= width_t'(1);
      build_case_table();
      repeat (10) tick();
      rst_n <= 1'b1;
      tick();
      tick();
      errs_before = errors;
      if (cw_trig !== 1'b0) report_mismatch("reset_values", "cw_trig_o", 0, cw_trig);
      if (armed !== 1'b0) report_mismatch("reset_values", "armed_o", 0, armed);
      if (trig_count !== '0) report_mismatch("reset_values", "trig_count_o", 0, trig_count);
      if (errors == errs_before) begin
         $display("PASS reset_values");
         tests_passed++;
      end
      else begin
         $display("FAIL reset_values");
         tests_failed++;
      end

      for (i = 0; i < name_c.size() && !timed_out; i++) begin
         errs_before = errors;
         rise_q.delete();
         width_q.delete();
         e_q.delete();
         tick();
         pattern       <= pat_c[i];
         mask          <= mask_c[i];
         pattern_bytes <= pbytes_t'(pbytes_c[i]);
         num_triggers  <= trig_cnt_t'(ntrig_c[i]);
         delay         <= delay_t'(delay_c[i]);
         width         <= width_t'(width_c[i]);
         if (arm_c[i] != 0) arm_session();
         tick();
         limit = delay_c[i] + width_c[i] + 64;
         for (p = 0; p < npkt_c[i]; p++) begin
            send_packet(i);
            if (overlap_c[i] == 0) begin
               seen = 1'b0;                   // wait for this packet's pulse, if any
               w    = 0;
               while (!(seen && !cw_trig) && w < limit) begin
                  tick();
                  w++;
                  if (cw_trig) seen = 1'b1;
               end
            end
         end
         w = 0;
         while (w < limit) begin              // quiet window for late or extra pulses
            tick();
            w++;
         end
         if (cw_trig) begin
            $display("timeout: cw_trig_o still high at the end of test %s", name_c[i]);
            timed_out = 1'b1;
         end
         if (rise_q.size() != exp_c[i]) begin
            report_mismatch(name_c[i], "pulse count", exp_c[i], rise_q.size());
         end
         for (p = 0; p < rise_q.size() && p < exp_c[i]; p++) begin
            if (rise_q[p] - e_q[p] != delay_c[i] + 3) begin
               report_mismatch(name_c[i], "rise delay", delay_c[i] + 3, rise_q[p] - e_q[p]);
            end
            if (p < width_q.size() && width_q[p] != width_c[i]) begin
               report_mismatch(name_c[i], "pulse width", width_c[i], width_q[p]);
            end
         end
         exp_armed = (arm_c[i] != 0) && (exp_c[i] < ntrig_c[i]);
         if (armed !== exp_armed) report_mismatch(name_c[i], "armed_o", exp_armed, armed);
         if (arm_c[i] != 0 && trig_count !== trig_cnt_t'(exp_c[i])) begin
            report_mismatch(name_c[i], "trig_count_o", exp_c[i], trig_count);
         end
         if (errors == errs_before && !timed_out) begin
            $display("PASS %s", name_c[i]);
            tests_passed++;
         end
         else begin
            $display("FAIL %s", name_c[i]);
            tests_failed++;
         end
      end

      $display("tests passed %0d, tests failed %0d, errors %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0 && !timed_out) begin
         $display("All checks passed");
      end
      else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+include
src/pw_cfg_pkg.sv
src/pw_trig_pkg.sv
src/timer_if.sv
src/usb_pattern_matcher.sv
src/trigger_sequencer.sv
src/trigger_timer.sv
src/pw_sniffer_top.sv
tb/tb_pw_sniffer.sv
